/* hdl/hazardPkg.sv */
package hazardPkg;

	// Register number width of the integer register file
	parameter int RegAddrWidth = 5;

	// Forwarding source of one operand
	typedef enum logic [1:0] {
		BYP_NONE = 2'd0, // Register file value
		BYP_MEM1 = 2'd1, // MEM1 result
		BYP_MEM2 = 2'd2, // MEM2 result
		BYP_WB   = 2'd3  // WB result
	} bypassSel_t;

	// Operation started on the HI/LO unit
	typedef enum logic [1:0] {
		HL_NONE = 2'd0,
		HL_MULT = 2'd1, // Multiply
		HL_DIV  = 2'd2  // Divide
	} hiloOp_t;

	// Data-cache wait states
	typedef enum logic [0:0] {
		MW_IDLE = 1'b0, // No access outstanding
		MW_BUSY = 1'b1  // Miss in progress
	} memWaitState_t;

endpackage

/* hdl/bypass.sv */
`timescale 1ns/1ns

module bypass import hazardPkg::*; (
	input  logic [RegAddrWidth-1:0] idRs,
	input  logic [RegAddrWidth-1:0] idRt,
	input  logic [RegAddrWidth-1:0] exRs,
	input  logic [RegAddrWidth-1:0] exRt,
	input  logic [RegAddrWidth-1:0] mem1Rd,
	input  logic [RegAddrWidth-1:0] mem2Rd,
	input  logic [RegAddrWidth-1:0] wbRd,
	input  logic                    mem1RfWr,
	input  logic                    mem2RfWr,
	input  logic                    wbRfWr,
	input  logic                    bjOp,
	output bypassSel_t              exRsSel,
	output bypassSel_t              exRtSel,
	output bypassSel_t              idRsSel,
	output bypassSel_t              idRtSel
);

	logic mem1Ok; // Stage writes a nonzero register
	logic mem2Ok;
	logic wbOk;

	// Youngest producer wins
	function automatic bypassSel_t pickEx(input logic m1Hit, input logic m2Hit,
			input logic wbHit);
		if (m1Hit)
			return BYP_MEM1;
		else if (m2Hit)
			return BYP_MEM2;
		else if (wbHit)
			return BYP_WB;
		else
			return BYP_NONE;
	endfunction

	// Branch compare in ID sees only the MEM1 and MEM2 results
	function automatic bypassSel_t pickId(input logic branch, input logic m1Hit,
			input logic m2Hit);
		if (branch && m1Hit)
			return BYP_MEM1;
		else if (branch && m2Hit)
			return BYP_MEM2;
		else
			return BYP_NONE;
	endfunction

	assign mem1Ok = mem1RfWr && (mem1Rd != '0);
	assign mem2Ok = mem2RfWr && (mem2Rd != '0);
	assign wbOk   = wbRfWr && (wbRd != '0);

	assign exRsSel = pickEx(mem1Ok && (mem1Rd == exRs), mem2Ok && (mem2Rd == exRs),
			wbOk && (wbRd == exRs));
	assign exRtSel = pickEx(mem1Ok && (mem1Rd == exRt), mem2Ok && (mem2Rd == exRt),
			wbOk && (wbRd == exRt));
	assign idRsSel = pickId(bjOp, mem1Ok && (mem1Rd == idRs), mem2Ok && (mem2Rd == idRs));
	assign idRtSel = pickId(bjOp, mem1Ok && (mem1Rd == idRt), mem2Ok && (mem2Rd == idRt));

endmodule

/* hdl/stall.sv */
`timescale 1ns/1ns

module stall import hazardPkg::*; (
	input  logic                    clk,
	input  logic                    rst_sign,
	input  logic [RegAddrWidth-1:0] idRs,
	input  logic [RegAddrWidth-1:0] idRt,
	input  logic [RegAddrWidth-1:0] exRt,
	input  logic [RegAddrWidth-1:0] mem1Rt,
	input  logic [RegAddrWidth-1:0] mem2Rt,
	input  logic                    exDmRd,
	input  logic                    exCp0Rd,
	input  logic                    mem1DmRd,
	input  logic                    mem1Cp0Rd,
	input  logic                    mem2DmRd,
	input  logic                    mem2Cp0Rd,
	input  logic                    exRfWr,
	input  logic                    mem2RfWr,
	input  logic                    bjOp,
	input  logic                    exMem1,
	input  logic                    eretFlush,
	input  logic                    memStall,
	input  logic                    hiloBusy,
	input  logic                    hiloVisit,
	output logic                    pcWr,
	output logic                    ifIdWr,
	output logic                    idExWr,
	output logic                    exMem1Wr,
	output logic                    mem1Mem2Wr,
	output logic                    mem2WbWr,
	output logic                    bubbleSel,
	output logic                    instSramEn,
	output logic                    isStall
);

	logic exUse;      // ID reads the EX destination
	logic mem1Use;
	logic mem2Use;
	logic hiloHold;
	logic loadUseEx;
	logic loadUseMem1;
	logic branchMem2;
	logic branchEx;
	logic frontHold;  // Any of the interlocks below memStall

	assign exUse   = (exRt == idRs) || (exRt == idRt);
	assign mem1Use = (mem1Rt == idRs) || (mem1Rt == idRt);
	assign mem2Use = (mem2Rt == idRs) || (mem2Rt == idRt);

	assign hiloHold    = hiloBusy && hiloVisit;
	assign loadUseEx   = (exDmRd || exCp0Rd) && exUse;
	assign loadUseMem1 = (mem1DmRd || mem1Cp0Rd) && mem1Use;
	assign branchMem2  = bjOp && mem2RfWr && (mem2DmRd || mem2Cp0Rd) && mem2Use;
	assign branchEx    = bjOp && exRfWr && exUse;

	// These interlocks all produce the same enable pattern
	assign frontHold = hiloHold || loadUseEx || loadUseMem1 || branchMem2 || branchEx;

	always_comb begin
		pcWr       = 1'b1; // Free-running pipeline by default
		ifIdWr     = 1'b1;
		idExWr     = 1'b1;
		exMem1Wr   = 1'b1;
		mem1Mem2Wr = 1'b1;
		mem2WbWr   = 1'b1;
		bubbleSel  = 1'b0;
		instSramEn = 1'b1;
		if (rst_sign) begin
			pcWr       = 1'b0; // Front held, bubbles flush the back
			ifIdWr     = 1'b0;
			instSramEn = 1'b0;
			bubbleSel  = 1'b1;
		end else if (exMem1 || eretFlush) begin
			mem1Mem2Wr = 1'b0; // Faulting instruction must not retire
			mem2WbWr   = 1'b0;
		end else if (memStall) begin
			pcWr       = 1'b0;
			ifIdWr     = 1'b0;
			idExWr     = 1'b0;
			exMem1Wr   = 1'b0;
			mem1Mem2Wr = 1'b0;
			mem2WbWr   = 1'b0;
			instSramEn = 1'b0;
			bubbleSel  = 1'b1;
		end else if (frontHold) begin
			pcWr       = 1'b0;
			ifIdWr     = 1'b0;
			instSramEn = 1'b0;
			bubbleSel  = 1'b1; // Bubble into EX
		end
	end

	assign isStall = ~pcWr;

endmodule

/* hdl/memWaitFsm.sv */
`timescale 1ns/1ns

module memWaitFsm import hazardPkg::*; (
	input  logic clk,
	input  logic rst_sign,
	input  logic dCacheEn,
	input  logic dCacheDataOk,
	input  logic iCacheDataOk,
	output logic memStall
);

	memWaitState_t state;
	memWaitState_t stateNext;
	logic          dWait; // Data side not ready

	always_ff @(posedge clk) begin
		if (rst_sign)
			state <= MW_IDLE;
		else
			state <= stateNext;
	end

	always_comb begin
		stateNext = state;
		dWait     = 1'b0;
		case (state)
			MW_IDLE: begin
				if (dCacheEn && !dCacheDataOk) begin
					dWait     = 1'b1; // Miss starts
					stateNext = MW_BUSY;
				end
			end
			MW_BUSY: begin
				if (dCacheDataOk)
					stateNext = MW_IDLE; // Data returned this cycle
				else
					dWait = 1'b1;
			end
			default: stateNext = MW_IDLE;
		endcase
	end

	// Instruction fetch miss also freezes everything
	assign memStall = dWait || !iCacheDataOk;

endmodule

/* hdl/hiloTimer.sv */
`timescale 1ns/1ns

module hiloTimer import hazardPkg::*; #(
	parameter int MulCycles = 4,
	parameter int DivCycles = 33
) (
	input  logic    clk,
	input  logic    rst_sign,
	input  hiloOp_t hiloOp,
	output logic    hiloBusy
);

	localparam int MaxCycles = (MulCycles > DivCycles) ? MulCycles : DivCycles;
	localparam int CntWidth  = $clog2(MaxCycles + 1);

	localparam logic [CntWidth-1:0] MulLoad = CntWidth'(MulCycles);
	localparam logic [CntWidth-1:0] DivLoad = CntWidth'(DivCycles);

	logic [CntWidth-1:0] count; // Remaining busy cycles

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			count <= '0;
		end else if (count != '0) begin
			count <= count - 1'b1; // New opcodes dropped while busy
		end else begin
			case (hiloOp)
				HL_MULT: count <= MulLoad;
				HL_DIV:  count <= DivLoad;
				default: count <= '0;
			endcase
		end
	end

	// Busy for exactly the loaded number of cycles
	assign hiloBusy = (count != '0);

endmodule

/* hdl/hazardCtrl.sv */
`timescale 1ns/1ns

module hazardCtrl import hazardPkg::*; #(
	parameter int MulCycles = 4,
	parameter int DivCycles = 33
) (
	input  logic                    clk,
	input  logic                    rst_sign,
	input  logic [RegAddrWidth-1:0] idRs,
	input  logic [RegAddrWidth-1:0] idRt,
	input  logic [RegAddrWidth-1:0] exRs,
	input  logic [RegAddrWidth-1:0] exRt,
	input  logic [RegAddrWidth-1:0] mem1Rd,
	input  logic [RegAddrWidth-1:0] mem2Rd,
	input  logic [RegAddrWidth-1:0] wbRd,
	input  logic [RegAddrWidth-1:0] mem1Rt,
	input  logic [RegAddrWidth-1:0] mem2Rt,
	input  logic                    exRfWr,
	input  logic                    mem1RfWr,
	input  logic                    mem2RfWr,
	input  logic                    wbRfWr,
	input  logic                    bjOp,
	input  logic                    exDmRd,
	input  logic                    exCp0Rd,
	input  logic                    mem1DmRd,
	input  logic                    mem1Cp0Rd,
	input  logic                    mem2DmRd,
	input  logic                    mem2Cp0Rd,
	input  logic                    exMem1,
	input  logic                    eretFlush,
	input  logic                    dCacheEn,
	input  logic                    dCacheDataOk,
	input  logic                    iCacheDataOk,
	input  hiloOp_t                 hiloOp,
	input  logic                    hiloVisit,
	output bypassSel_t              exRsSel,
	output bypassSel_t              exRtSel,
	output bypassSel_t              idRsSel,
	output bypassSel_t              idRtSel,
	output logic                    pcWr,
	output logic                    ifIdWr,
	output logic                    idExWr,
	output logic                    exMem1Wr,
	output logic                    mem1Mem2Wr,
	output logic                    mem2WbWr,
	output logic                    bubbleSel,
	output logic                    instSramEn,
	output logic                    isStall
);

	logic memStall; // Cache wait into stall priority
	logic hiloBusy;

	bypass u_bypass (
		.idRs(idRs), .idRt(idRt), .exRs(exRs), .exRt(exRt),
		.mem1Rd(mem1Rd), .mem2Rd(mem2Rd), .wbRd(wbRd),
		.mem1RfWr(mem1RfWr), .mem2RfWr(mem2RfWr), .wbRfWr(wbRfWr), .bjOp(bjOp),
		.exRsSel(exRsSel), .exRtSel(exRtSel), .idRsSel(idRsSel), .idRtSel(idRtSel)
	);

	stall u_stall (
		.clk(clk), .rst_sign(rst_sign),
		.idRs(idRs), .idRt(idRt), .exRt(exRt), .mem1Rt(mem1Rt), .mem2Rt(mem2Rt),
		.exDmRd(exDmRd), .exCp0Rd(exCp0Rd), .mem1DmRd(mem1DmRd), .mem1Cp0Rd(mem1Cp0Rd),
		.mem2DmRd(mem2DmRd), .mem2Cp0Rd(mem2Cp0Rd), .exRfWr(exRfWr), .mem2RfWr(mem2RfWr),
		.bjOp(bjOp), .exMem1(exMem1), .eretFlush(eretFlush),
		.memStall(memStall), .hiloBusy(hiloBusy), .hiloVisit(hiloVisit),
		.pcWr(pcWr), .ifIdWr(ifIdWr), .idExWr(idExWr), .exMem1Wr(exMem1Wr),
		.mem1Mem2Wr(mem1Mem2Wr), .mem2WbWr(mem2WbWr), .bubbleSel(bubbleSel),
		.instSramEn(instSramEn), .isStall(isStall)
	);

	memWaitFsm u_memWaitFsm (
		.clk(clk), .rst_sign(rst_sign),
		.dCacheEn(dCacheEn), .dCacheDataOk(dCacheDataOk), .iCacheDataOk(iCacheDataOk),
		.memStall(memStall)
	);

	hiloTimer #(
		.MulCycles(MulCycles),
		.DivCycles(DivCycles)
	) u_hiloTimer (
		.clk(clk), .rst_sign(rst_sign), .hiloOp(hiloOp), .hiloBusy(hiloBusy)
	);

endmodule

/* verification/hazardCtrlTb.sv */
`timescale 1ns/1ns

module hazardCtrlTb import hazardPkg::*; ();

	localparam int MulCycles = 4;
	localparam int DivCycles = 33;
	localparam int MaxCycles = 400; // Test lengths with one divide plus margin

	logic clk;
	logic rst_sign;
	logic [RegAddrWidth-1:0] idRs;
	logic [RegAddrWidth-1:0] idRt;
	logic [RegAddrWidth-1:0] exRs;
	logic [RegAddrWidth-1:0] exRt;
	logic [RegAddrWidth-1:0] mem1Rd;
	logic [RegAddrWidth-1:0] mem2Rd;
	logic [RegAddrWidth-1:0] wbRd;
	logic [RegAddrWidth-1:0] mem1Rt;
	logic [RegAddrWidth-1:0] mem2Rt;
	logic exRfWr;
	logic mem1RfWr;
	logic mem2RfWr;
	logic wbRfWr;
	logic bjOp;
	logic exDmRd;
	logic exCp0Rd;
	logic mem1DmRd;
	logic mem1Cp0Rd;
	logic mem2DmRd;
	logic mem2Cp0Rd;
	logic exMem1;
	logic eretFlush;
	logic dCacheEn;
	logic dCacheDataOk;
	logic iCacheDataOk;
	logic hiloVisit;
	hiloOp_t hiloOp;
	bypassSel_t exRsSel;
	bypassSel_t exRtSel;
	bypassSel_t idRsSel;
	bypassSel_t idRtSel;
	logic pcWr;
	logic ifIdWr;
	logic idExWr;
	logic exMem1Wr;
	logic mem1Mem2Wr;
	logic mem2WbWr;
	logic bubbleSel;
	logic instSramEn;
	logic isStall;

	int cycles = 0;
	int checks = 0;
	int errors = 0;

	hazardCtrl #(
		.MulCycles(MulCycles),
		.DivCycles(DivCycles)
	) u_hazardCtrl (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MaxCycles) begin
			$display("Timeout after %0d cycles, a test never finished", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Inputs change 10 ns after the edge
	task automatic nextCycle();
		@(posedge clk);
		#10;
	endtask

	task automatic clearInputs();
		{idRs, idRt, exRs, exRt, mem1Rd, mem2Rd, wbRd, mem1Rt, mem2Rt} = '0;
		{exRfWr, mem1RfWr, mem2RfWr, wbRfWr, bjOp} = '0;
		{exDmRd, exCp0Rd, mem1DmRd, mem1Cp0Rd, mem2DmRd, mem2Cp0Rd} = '0;
		{exMem1, eretFlush, dCacheEn, dCacheDataOk, hiloVisit} = '0;
		iCacheDataOk = 1'b1; // Fetch side ready
		hiloOp       = HL_NONE;
	endtask

	function automatic logic [RegAddrWidth-1:0] randReg();
		return RegAddrWidth'(1 + ($urandom % 31));
	endfunction

	// Different nonzero register
	function automatic logic [RegAddrWidth-1:0] otherReg(input logic [RegAddrWidth-1:0] r);
		return RegAddrWidth'((r % 31) + 1);
	endfunction

	task automatic checkSel(input string name, input bypassSel_t expVal,
			input bypassSel_t actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("** Error at %0t ns: %s expected %s, got %s", $time, name,
					expVal.name(), actVal.name());
		end
	endtask

	task automatic checkBit(input string name, input logic expVal, input logic actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expVal, actVal);
		end
	endtask

	// Front enables, later enables and bubble select as one pattern
	task automatic expectEnables(input logic front, input logic back, input logic bubble);
		checkBit("pcWr", front, pcWr);
		checkBit("ifIdWr", front, ifIdWr);
		checkBit("instSramEn", front, instSramEn);
		checkBit("idExWr", back, idExWr);
		checkBit("exMem1Wr", back, exMem1Wr);
		checkBit("mem1Mem2Wr", back, mem1Mem2Wr);
		checkBit("mem2WbWr", back, mem2WbWr);
		checkBit("bubbleSel", bubble, bubbleSel);
		checkBit("isStall", ~front, isStall);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errors == errBefore)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d mismatches", name, errors - errBefore);
	endtask

	task automatic forwardPriority();
		logic [RegAddrWidth-1:0] r;
		logic [RegAddrWidth-1:0] o;
		int errBefore;
		errBefore = errors;
		r = randReg();
		o = otherReg(r);
		nextCycle();
		clearInputs();
		exRs = r;
		exRt = o;
		{mem1Rd, mem2Rd, wbRd} = {r, r, r};
		{mem1RfWr, mem2RfWr, wbRfWr} = 3'b111;
		#5;
		checkSel("exRsSel", BYP_MEM1, exRsSel); // All three match
		checkSel("exRtSel", BYP_NONE, exRtSel);
		nextCycle();
		mem1RfWr = 1'b0;
		#5;
		checkSel("exRsSel", BYP_MEM2, exRsSel);
		nextCycle();
		mem2Rd = o;
		#5;
		checkSel("exRsSel", BYP_WB, exRsSel);
		checkSel("exRtSel", BYP_MEM2, exRtSel);
		nextCycle();
		mem1RfWr = 1'b1;
		mem1Rd   = o;
		wbRfWr   = 1'b0; // WB match no longer counts
		#5;
		checkSel("exRsSel", BYP_NONE, exRsSel);
		checkSel("exRtSel", BYP_MEM1, exRtSel);
		nextCycle();
		{exRs, exRt, mem1Rd, mem2Rd, wbRd} = '0;
		wbRfWr = 1'b1;
		#5;
		checkSel("exRsSel", BYP_NONE, exRsSel); // r0 is never forwarded
		checkSel("exRtSel", BYP_NONE, exRtSel);
		reportTest("forwarding priority", errBefore);
	endtask

	task automatic branchForward();
		logic [RegAddrWidth-1:0] r;
		logic [RegAddrWidth-1:0] o;
		int errBefore;
		errBefore = errors;
		r = randReg();
		o = otherReg(r);
		nextCycle();
		clearInputs();
		idRs = r;
		idRt = o;
		{mem1Rd, mem2Rd, wbRd} = {r, o, r};
		{mem1RfWr, mem2RfWr, wbRfWr} = 3'b111;
		#5;
		checkSel("idRsSel", BYP_NONE, idRsSel);
		checkSel("idRtSel", BYP_NONE, idRtSel);
		nextCycle();
		bjOp = 1'b1;
		#5;
		checkSel("idRsSel", BYP_MEM1, idRsSel);
		checkSel("idRtSel", BYP_MEM2, idRtSel);
		nextCycle();
		{mem1RfWr, mem2RfWr} = 2'b00; // Only WB left
		#5;
		checkSel("idRsSel", BYP_NONE, idRsSel);
		checkSel("idRtSel", BYP_NONE, idRtSel);
		reportTest("branch forwarding", errBefore);
	endtask

	// Load in EX whose destination is the ID rs operand
	task automatic driveLoadUse();
		logic [RegAddrWidth-1:0] r;
		r = randReg();
		nextCycle();
		clearInputs();
		idRs   = r;
		idRt   = otherReg(r);
		exRt   = r;
		exDmRd = 1'b1;
	endtask

	task automatic loadUseInterlock();
		int errBefore;
		errBefore = errors;
		driveLoadUse();
		#5;
		expectEnables(1'b0, 1'b1, 1'b1);
		reportTest("load-use interlock", errBefore);
	endtask

	task automatic flushOverStall();
		int errBefore;
		errBefore = errors;
		driveLoadUse();
		exMem1 = 1'b1;
		#5;
		checkBit("pcWr", 1'b1, pcWr);
		checkBit("mem1Mem2Wr", 1'b0, mem1Mem2Wr);
		checkBit("mem2WbWr", 1'b0, mem2WbWr);
		checkBit("bubbleSel", 1'b0, bubbleSel);
		nextCycle();
		exMem1    = 1'b0;
		eretFlush = 1'b1;
		#5;
		checkBit("pcWr", 1'b1, pcWr);
		checkBit("mem2WbWr", 1'b0, mem2WbWr);
		reportTest("flush over stall", errBefore);
	endtask

	task automatic dataCacheMiss();
		int waitCycles;
		int errBefore;
		errBefore = errors;
		waitCycles = 2 + ($urandom % 6);
		nextCycle();
		clearInputs();
		dCacheEn = 1'b1; // One-cycle access strobe
		#5;
		expectEnables(1'b0, 1'b0, 1'b1);
		for (int i = 0; i < waitCycles; i++) begin
			nextCycle();
			dCacheEn = 1'b0; // Only the pending miss holds the stall now
			#5;
			expectEnables(1'b0, 1'b0, 1'b1);
		end
		nextCycle();
		dCacheDataOk = 1'b1; // Data returns
		#5;
		expectEnables(1'b1, 1'b1, 1'b0);
		nextCycle();
		dCacheDataOk = 1'b0;
		#5;
		expectEnables(1'b1, 1'b1, 1'b0);
		nextCycle();
		iCacheDataOk = 1'b0;
		#5;
		expectEnables(1'b0, 1'b0, 1'b1);
		reportTest("data-cache miss", errBefore);
	endtask

	task automatic hiloLatency();
		int errBefore;
		errBefore = errors;
		nextCycle();
		clearInputs();
		hiloVisit = 1'b1;
		hiloOp    = HL_MULT;
		#5;
		checkBit("pcWr", 1'b1, pcWr);
		for (int i = 0; i < MulCycles; i++) begin
			nextCycle();
			hiloOp = HL_NONE;
			#5;
			checkBit("pcWr", 1'b0, pcWr);
		end
		nextCycle();
		hiloOp = HL_DIV;
		#5;
		checkBit("pcWr", 1'b1, pcWr);
		for (int i = 0; i < DivCycles; i++) begin
			nextCycle();
			hiloOp = (i == 3) ? HL_MULT : HL_NONE; // Dropped while busy
			#5;
			checkBit("pcWr", 1'b0, pcWr);
		end
		nextCycle();
		hiloVisit = 1'b0;
		hiloOp    = HL_MULT;
		#5;
		checkBit("pcWr", 1'b1, pcWr);
		for (int i = 0; i < MulCycles; i++) begin
			nextCycle();
			hiloOp = HL_NONE;
			#5;
			checkBit("pcWr", 1'b1, pcWr);
		end
		reportTest("hi/lo latency", errBefore);
	endtask

	initial begin
		void'($urandom(32'hf382));
		clearInputs();
		rst_sign = 1'b1;
		repeat (3) @(posedge clk);
		#10;
		rst_sign = 1'b0;
		forwardPriority();
		branchForward();
		loadUseInterlock();
		flushOverStall();
		dataCacheMiss();
		hiloLatency();
		$display("Summary: %0d checks, %0d passed, %0d failed", checks, checks - errors, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tb.f */
hdl/hazardPkg.sv
hdl/bypass.sv
hdl/stall.sv
hdl/memWaitFsm.sv
hdl/hiloTimer.sv
hdl/hazardCtrl.sv
verification/hazardCtrlTb.sv

/* Bender.yml */
package:
  name: hazard_ctrl

sources:
  - hdl/hazardPkg.sv
  - hdl/bypass.sv
  - hdl/stall.sv
  - hdl/memWaitFsm.sv
  - hdl/hiloTimer.sv
  - hdl/hazardCtrl.sv
  - target: test
    files:
      - verification/hazardCtrlTb.sv
